//--- dbg_bridge.f
hw/dbg_pkg.sv
hw/uart_rx.sv
hw/cmd_decoder.sv
hw/cmd_exec.sv
hw/dbg_bridge_top.sv
tests/dbg_bridge_asserts.sv
tests/dbg_bridge_tb.sv

//--- hw/cmd_decoder.sv
module cmd_decoder (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic [7:0]                i_char,
    input  logic                      i_stb,
    output dbg_pkg::cmd_e             o_cmd,
    output logic [dbg_pkg::DATA_W-1:0] o_value,
    output logic                      o_cmd_stb,
    output logic                      o_err
);

    import dbg_pkg::*;

    // character classes produced by stage one
    typedef enum logic [1:0] {
        CLS_DIGIT,
        CLS_CMD,
        CLS_END,
        CLS_BAD
    } char_cls_e;

    // stage one registers
    logic              s1_vld;
    char_cls_e         s1_cls;
    logic [3:0]        s1_nib;
    cmd_e              s1_cmd;

    // stage two state
    logic              pend_vld;  // a command letter is waiting for its value
    cmd_e              pend_cmd;
    logic [DATA_W-1:0] acc;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) s1_vld <= 1'b0;
        else          s1_vld <= i_stb;
    end

    // classify the incoming character
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            s1_nib <= i_char[3:0];
            s1_cmd <= CMD_SPECIAL;
            case (i_char) inside
                [8'h30:8'h39]: s1_cls <= CLS_DIGIT;  // '0'..'9'
                [8'h61:8'h66]: begin                 // 'a'..'f'
                    s1_cls <= CLS_DIGIT;
                    s1_nib <= i_char[3:0] + 4'd9;
                end
                CH_READ: begin
                    s1_cls <= CLS_CMD;
                    s1_cmd <= CMD_READ;
                end
                CH_WRITE: begin
                    s1_cls <= CLS_CMD;
                    s1_cmd <= CMD_WRITE;
                end
                CH_ADDR: begin
                    s1_cls <= CLS_CMD;
                    s1_cmd <= CMD_ADDR;
                end
                CH_SPECIAL: s1_cls <= CLS_CMD;
                CH_END:     s1_cls <= CLS_END;
                default:    s1_cls <= CLS_BAD;
            endcase
        end
    end

    // stage two control
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pend_vld  <= 1'b0;
            o_cmd_stb <= 1'b0;
            o_err     <= 1'b0;
        end else begin
            o_cmd_stb <= 1'b0;
            o_err     <= 1'b0;
            if (s1_vld) begin
                case (s1_cls)
                    CLS_CMD, CLS_END: begin
                        o_cmd_stb <= pend_vld;  // flush only if something was pending
                        pend_vld  <= (s1_cls == CLS_CMD);
                    end
                    CLS_BAD: begin
                        pend_vld <= 1'b0;  // drop the half-built command
                        o_err    <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // stage two data path
    always_ff @(posedge i_clk) begin
        if (s1_vld) begin
            if (s1_cls == CLS_DIGIT && pend_vld)
                acc <= {acc[DATA_W-5:0], s1_nib};  // new digit enters from the right
            if (s1_cls == CLS_CMD || s1_cls == CLS_END) begin
                o_cmd    <= pend_cmd;
                o_value  <= acc;
                pend_cmd <= s1_cmd;
                acc      <= '0;
            end
        end
    end

endmodule

//--- hw/cmd_exec.sv
module cmd_exec #(
    parameter int REG_COUNT = 8
) (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  dbg_pkg::cmd_e                i_cmd,
    input  logic [dbg_pkg::DATA_W-1:0]   i_value,
    input  logic                         i_cmd_stb,
    output logic [dbg_pkg::DATA_W-1:0]   o_rd_data,
    output logic                         o_rd_valid,
    output logic [$clog2(REG_COUNT)-1:0] o_addr
);

    import dbg_pkg::*;

    localparam int AW = $clog2(REG_COUNT);

    logic [DATA_W-1:0] bank [REG_COUNT];

    logic do_read;
    logic do_write;
    logic do_addr;

    assign do_read  = i_cmd_stb && (i_cmd == CMD_READ);
    assign do_write = i_cmd_stb && (i_cmd == CMD_WRITE);
    assign do_addr  = i_cmd_stb && (i_cmd == CMD_ADDR);

    // address register and read strobe
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_addr     <= '0;
            o_rd_valid <= 1'b0;
        end else begin
            o_rd_valid <= do_read;
            if (do_addr)
                o_addr <= i_value[AW-1:0];  // wraps modulo REG_COUNT
            else if (do_read || do_write)
                o_addr <= o_addr + 1'b1;
        end
    end

    // register bank, comes up all zero
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                bank[i] <= '0;
            end
        end else if (do_write) begin
            bank[o_addr] <= i_value;
        end
    end

    // read data goes out with o_rd_valid
    always_ff @(posedge i_clk) begin
        if (do_read) o_rd_data <= bank[o_addr];
    end

endmodule

//--- hw/dbg_bridge_top.sv
module dbg_bridge_top #(
    parameter logic [15:0] CLKS_PER_BIT = 16'd8,
    parameter int          REG_COUNT    = 8
) (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_rx,
    output logic [dbg_pkg::DATA_W-1:0]   o_rd_data,
    output logic                         o_rd_valid,
    output logic [$clog2(REG_COUNT)-1:0] o_addr,
    output logic                         o_err
);

    import dbg_pkg::*;

    logic [7:0]        rx_byte;
    logic              rx_stb;
    cmd_e              cmd;
    logic [DATA_W-1:0] cmd_value;
    logic              cmd_stb;

    // serial line to bytes
    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_rx (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_rx     (i_rx),
        .o_rx_byte(rx_byte),
        .o_rx_stb (rx_stb)
    );

    // bytes to command words
    cmd_decoder u_cmd_decoder (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_char   (rx_byte),
        .i_stb    (rx_stb),
        .o_cmd    (cmd),
        .o_value  (cmd_value),
        .o_cmd_stb(cmd_stb),
        .o_err    (o_err)
    );

    // command words to register accesses
    cmd_exec #(
        .REG_COUNT(REG_COUNT)
    ) u_cmd_exec (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_cmd     (cmd),
        .i_value   (cmd_value),
        .i_cmd_stb (cmd_stb),
        .o_rd_data (o_rd_data),
        .o_rd_valid(o_rd_valid),
        .o_addr    (o_addr)
    );

endmodule

//--- hw/dbg_pkg.sv
package dbg_pkg;

    // width of the accumulated value and of every bank register
    localparam int DATA_W = 32;

    // command codes in the order of the command letters R W A S
    typedef enum logic [1:0] {
        CMD_READ    = 2'd0,
        CMD_WRITE   = 2'd1,
        CMD_ADDR    = 2'd2,
        CMD_SPECIAL = 2'd3
    } cmd_e;

    // ascii command letters
    localparam logic [7:0] CH_READ    = 8'h52; // 'R'
    localparam logic [7:0] CH_WRITE   = 8'h57; // 'W'
    localparam logic [7:0] CH_ADDR    = 8'h41; // 'A'
    localparam logic [7:0] CH_SPECIAL = 8'h53; // 'S'

    // terminator, flushes the pending command without opening a new one
    localparam logic [7:0] CH_END     = 8'h45; // 'E'

endpackage

//--- hw/uart_rx.sv
module uart_rx #(
    parameter logic [15:0] CLKS_PER_BIT = 16'd8
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_rx,
    output logic [7:0] o_rx_byte,
    output logic       o_rx_stb
);

    localparam logic [15:0] HALF_BIT = CLKS_PER_BIT >> 1;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e   state;
    logic [1:0]  rx_sync;  // two-flop synchronizer
    logic        rx_prev;  // previous synchronized level for edge detect
    logic [15:0] clk_cnt;
    logic [2:0]  bit_idx;
    logic [7:0]  shift;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_sync  <= 2'b11;  // idle line is high
            rx_prev  <= 1'b1;
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            o_rx_stb <= 1'b0;
        end else begin
            rx_sync  <= {rx_sync[0], i_rx};
            rx_prev  <= rx_sync[1];
            o_rx_stb <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (rx_prev && !rx_sync[1]) state <= RX_START; // falling start edge
                end
                RX_START: begin
                    clk_cnt <= clk_cnt + 16'd1;
                    if (clk_cnt == HALF_BIT - 16'd1) begin
                        clk_cnt <= '0;
                        // glitch rejection at the middle of the start bit
                        state   <= rx_sync[1] ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    clk_cnt <= clk_cnt + 16'd1;
                    if (clk_cnt == CLKS_PER_BIT - 16'd1) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    clk_cnt <= clk_cnt + 16'd1;
                    if (clk_cnt == CLKS_PER_BIT - 16'd1) begin
                        clk_cnt  <= '0;
                        state    <= RX_IDLE;
                        o_rx_stb <= rx_sync[1];  // low stop bit drops the frame
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // data path, lsb arrives first
    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && clk_cnt == CLKS_PER_BIT - 16'd1)
            shift <= {rx_sync[1], shift[7:1]};
        if (state == RX_STOP && clk_cnt == CLKS_PER_BIT - 16'd1 && rx_sync[1])
            o_rx_byte <= shift;  // held until the next good frame
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the dbg_bridge testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f dbg_bridge.f \
    --top-module dbg_bridge_tb \
    --Mdir obj_dir \
    -o dbg_bridge_sim

./obj_dir/dbg_bridge_sim | tee sim.log

if grep -qx "test passed" sim.log; then
    echo "run_sim: pass message found in sim.log"
    exit 0
else
    echo "run_sim: pass message missing from sim.log"
    exit 1
fi

//--- tests/dbg_bridge_asserts.sv
module dbg_bridge_asserts #(
    parameter bit CHECK_READ = 1'b0  // set where i_stb_b is the read strobe
) (
    input logic          i_clk,
    input logic          i_rst_n,
    input logic          i_stb_a,
    input logic          i_stb_b,
    input dbg_pkg::cmd_e i_cmd
);

    import dbg_pkg::*;

    // every strobe is a single-cycle pulse
    a_stb_a_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_stb_a |=> !i_stb_a) else $error("strobe a high in two consecutive cycles");

    a_stb_b_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_stb_b |=> !i_stb_b) else $error("strobe b high in two consecutive cycles");

    // read command strobe is followed by o_rd_valid one cycle later
    a_read_follows: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (CHECK_READ && i_stb_a && i_cmd == CMD_READ) |=> i_stb_b)
        else $error("read command not followed by o_rd_valid");

    // and o_rd_valid never shows up without one
    a_read_caused: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (CHECK_READ && i_stb_b) |-> $past(i_stb_a && i_cmd == CMD_READ))
        else $error("o_rd_valid without a preceding read command");

endmodule

bind cmd_decoder dbg_bridge_asserts #(.CHECK_READ(1'b0)) u_dec_checks (
    .i_clk  (i_clk),
    .i_rst_n(i_rst_n),
    .i_stb_a(o_cmd_stb),
    .i_stb_b(o_err),
    .i_cmd  (o_cmd)
);

bind cmd_exec dbg_bridge_asserts #(.CHECK_READ(1'b1)) u_exec_checks (
    .i_clk  (i_clk),
    .i_rst_n(i_rst_n),
    .i_stb_a(i_cmd_stb),
    .i_stb_b(o_rd_valid),
    .i_cmd  (i_cmd)
);

//--- tests/dbg_bridge_tb.sv
module dbg_bridge_tb;

    import dbg_pkg::*;

    localparam int CPB          = 8;            // clocks per serial bit
    localparam int REG_COUNT    = 8;
    localparam int AW           = $clog2(REG_COUNT);
    localparam int CLK_PERIOD   = 4;
    localparam int N_TESTS      = 6;
    localparam int FRAME_CYCLES = 10 * CPB;     // start, 8 data, stop
    localparam int DRAIN_CYCLES = 2 * FRAME_CYCLES;

    logic              i_clk;
    logic              i_rst_n;
    logic              i_rx;
    logic [DATA_W-1:0] o_rd_data;
    logic              o_rd_valid;
    logic [AW-1:0]     o_addr;
    logic              o_err;

    // stimulus table with hand-derived final address and error count
    string test_name [N_TESTS];
    string test_stim [N_TESTS];
    int    exp_addr_tbl [N_TESTS];
    int    exp_err_tbl [N_TESTS];

    // reference model of the bridge
    logic              m_pend;
    logic [7:0]        m_cmd;
    logic [DATA_W-1:0] m_val;
    int                m_addr;
    logic [DATA_W-1:0] m_bank [REG_COUNT];
    logic [DATA_W-1:0] exp_reads [$];

    logic [31:0]       lcg_state;
    logic [DATA_W-1:0] exp_word;
    int                errors;
    int                obs_err;
    int                tests_ok;
    bit                watch_armed;
    longint            watch_limit;

    dbg_bridge_top #(
        .CLKS_PER_BIT(16'(CPB)),
        .REG_COUNT   (REG_COUNT)
    ) dut0 (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_rx      (i_rx),
        .o_rd_data (o_rd_data),
        .o_rd_valid(o_rd_valid),
        .o_addr    (o_addr),
        .o_err     (o_err)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic model_exec(input logic [7:0] cmd, input logic [DATA_W-1:0] val);
        if (cmd == CH_ADDR) begin
            m_addr = int'(val % REG_COUNT);
        end else if (cmd == CH_WRITE) begin
            m_bank[m_addr] = val;
            m_addr = (m_addr + 1) % REG_COUNT;
        end else if (cmd == CH_READ) begin
            exp_reads.push_back(m_bank[m_addr]);
            m_addr = (m_addr + 1) % REG_COUNT;
        end
        // S is accepted and ignored
    endtask

    task automatic model_char(input logic [7:0] c);
        logic [3:0] nib;
        bit         is_digit;
        is_digit = 1'b0;
        nib = 4'h0;
        if (c >= 8'h30 && c <= 8'h39) begin
            nib = 4'(c - 8'h30);
            is_digit = 1'b1;
        end else if (c >= 8'h61 && c <= 8'h66) begin
            nib = 4'(c - 8'h57);  // 'a' is ten
            is_digit = 1'b1;
        end
        if (is_digit) begin
            if (m_pend) m_val = {m_val[DATA_W-5:0], nib};
        end else if (c == CH_READ || c == CH_WRITE || c == CH_ADDR ||
                     c == CH_SPECIAL || c == CH_END) begin
            if (m_pend) model_exec(m_cmd, m_val);
            m_pend = (c != CH_END);
            m_cmd  = c;
            m_val  = '0;
        end else begin
            m_pend = 1'b0;  // bad character kills the pending command
        end
    endtask

    // one 8N1 frame, entered and left 1 unit after a rising edge
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            i_rx = frame[i];
            repeat (CPB) @(posedge i_clk);
            #1;
        end
    endtask

    task automatic load_table();
        string rnd;
        test_name[0] = "write_read";  test_stim[0] = "A3W1234abcdA3RE";
        exp_addr_tbl[0] = 4;          exp_err_tbl[0] = 0;
        test_name[1] = "addr_wrap";   test_stim[1] = "A7W11111111W22222222A7RRE";
        exp_addr_tbl[1] = 1;          exp_err_tbl[1] = 0;
        test_name[2] = "digit_accum"; test_stim[2] = "5a5aA2W123456789abcdefA2RE";
        exp_addr_tbl[2] = 3;          exp_err_tbl[2] = 0;
        test_name[3] = "bad_char";    test_stim[3] = "A2W12x34A2RA2Wf00dGA2RE";
        exp_addr_tbl[3] = 3;          exp_err_tbl[3] = 2;
        // the read right after S shows whether S moved the address or wrote data
        test_name[4] = "special_end"; test_stim[4] = "A5WcafeS1234ERA5RE";
        exp_addr_tbl[4] = 6;          exp_err_tbl[4] = 0;
        rnd = $sformatf("%c0", CH_ADDR);
        for (int k = 0; k < REG_COUNT; k++) begin
            rnd = {rnd, $sformatf("%c%08h", CH_WRITE, lcg_next())};
        end
        rnd = {rnd, $sformatf("%c0", CH_ADDR)};
        for (int k = 0; k < REG_COUNT; k++) begin
            rnd = {rnd, $sformatf("%c", CH_READ)};
        end
        test_name[5] = "random_rw";   test_stim[5] = {rnd, $sformatf("%c", CH_END)};
        exp_addr_tbl[5] = 0;          exp_err_tbl[5] = 0;  // eight reads wrap back to 0
    endtask

    task automatic run_test(input int t);
        string         s;
        int            err_before;
        int            obs_before;
        int            waited;
        logic [AW-1:0] exp_a;
        s = test_stim[t];
        err_before = errors;
        obs_before = obs_err;
        for (int i = 0; i < s.len(); i++) model_char(s[i]);
        for (int i = 0; i < s.len(); i++) send_byte(s[i]);
        waited = 0;
        while (exp_reads.size() != 0 && waited < DRAIN_CYCLES) begin
            @(posedge i_clk);
            waited++;
        end
        repeat (CPB) @(posedge i_clk);  // last frame clears the pipeline
        #1;
        if (exp_reads.size() != 0) begin
            $display("%0t: %0d expected reads never appeared on o_rd_valid",
                     $time, exp_reads.size());
            errors++;
            exp_reads.delete();
        end
        exp_a = AW'(exp_addr_tbl[t]);
        if (o_addr !== exp_a) begin
            $display("mismatch at %0t: o_addr got %0d expected %0d", $time, o_addr, exp_a);
            errors++;
        end
        if (obs_err - obs_before != exp_err_tbl[t]) begin
            $display("mismatch at %0t: o_err pulses got %0d expected %0d",
                     $time, obs_err - obs_before, exp_err_tbl[t]);
            errors++;
        end
        if (errors == err_before) tests_ok++;
        $display("%-12s %s", test_name[t], (errors == err_before) ? "ok" : "BAD");
    endtask

    // read and error monitor, samples away from the active edge
    always @(negedge i_clk) begin
        if (i_rst_n && o_rd_valid) begin
            if (exp_reads.size() == 0) begin
                $display("%0t: o_rd_valid pulsed with no read expected", $time);
                errors++;
            end else begin
                exp_word = exp_reads.pop_front();
                if (o_rd_data !== exp_word) begin
                    $display("mismatch at %0t: o_rd_data got %h expected %h",
                             $time, o_rd_data, exp_word);
                    errors++;
                end
            end
        end
        if (i_rst_n && o_err) obs_err++;
    end

    initial begin
        int total_chars;
        i_rst_n   = 1'b0;
        i_rx      = 1'b1;  // idle line
        errors    = 0;
        obs_err   = 0;
        tests_ok  = 0;
        lcg_state = 32'h5c9d9714;
        m_pend    = 1'b0;
        m_cmd     = 8'h00;
        m_val     = '0;
        m_addr    = 0;
        for (int i = 0; i < REG_COUNT; i++) m_bank[i] = '0;
        load_table();
        total_chars = 0;
        for (int t = 0; t < N_TESTS; t++) total_chars += test_stim[t].len();
        watch_limit = longint'(total_chars) * FRAME_CYCLES * CLK_PERIOD
                    + N_TESTS * (DRAIN_CYCLES + CPB) * CLK_PERIOD + 2000;
        watch_armed = 1'b1;
        repeat (16) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        repeat (4) @(posedge i_clk);
        #1;
        for (int t = 0; t < N_TESTS; t++) run_test(t);
        $display("summary: %0d of %0d tests ok, %0d errors", tests_ok, N_TESTS, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        wait (watch_armed);
        #(watch_limit);
        $display("watchdog: run did not finish within %0d time units", watch_limit);
        $display("test failed");
        $finish;
    end

endmodule
